/* run.sh */
#!/bin/sh
# build and run the commit unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module commit_tb -f sources.f -o commit_sim \
    && ./obj_dir/commit_sim | tee /dev/stderr | grep -qx "TEST PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sources.f */
src/commit_pkg.sv
src/exception_stage.sv
src/commit_buffer.sv
src/data_stage.sv
src/commit_unit.sv
verif/commit_tb.sv

/* src/commit_buffer.sv */
`timescale 1ns/1ps

module commit_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  finish,
    input  logic                  in_valid,
    input  commit_pkg::op_t       in_op,
    input  commit_pkg::word_t     in_pc,
    input  commit_pkg::word_t     in_result,
    input  commit_pkg::reg_addr_t in_dest,
    input  logic [1:0]            in_addr,
    input  commit_pkg::exc_code_t ex_code,
    input  logic                  ex_ll,
    output logic                  buf_valid,
    output commit_pkg::op_t       buf_op,
    output commit_pkg::word_t     buf_pc,
    output commit_pkg::word_t     buf_result,
    output commit_pkg::reg_addr_t buf_dest,
    output logic [1:0]            buf_addr_low,
    output commit_pkg::exc_code_t buf_code,
    output logic                  llbit
);
    import commit_pkg::*;

    logic holds_exc;

    assign holds_exc = buf_valid & (buf_code != exc_none);

    // an exception squashes whatever is accepted behind it
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            buf_valid <= 1'b0;
            buf_code  <= exc_none;
            llbit     <= 1'b0;
        end
        else if (holds_exc)
        begin
            buf_valid <= 1'b0;
            buf_code  <= exc_none;
            llbit     <= 1'b0;
        end
        else if (finish)
        begin
            buf_valid <= in_valid;
            if (in_valid)
                buf_code <= ex_code;
            else
                buf_code <= exc_none;
            if (in_valid && ex_ll)
                llbit <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (finish && in_valid)
        begin
            buf_op       <= in_op;
            buf_pc       <= in_pc;
            buf_result   <= in_result;
            buf_dest     <= in_dest;
            buf_addr_low <= in_addr;
        end
    end

    // link request only comes with a clean valid instruction
    a_ll_clean: assert property (@(posedge clk) disable iff (!rst_n)
        ex_ll |-> in_valid && ex_code == exc_none);

endmodule

/* src/commit_pkg.sv */
package commit_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // committed operation kinds
    typedef enum logic [2:0] {
        op_alu         = 3'd0,
        op_load_word   = 3'd1,
        op_load_half   = 3'd2,
        op_store_word  = 3'd3,
        op_load_linked = 3'd4,
        op_syscall     = 3'd5
    } op_t;

    // MIPS cause codes, exc_none sits on an unused code
    typedef enum logic [4:0] {
        exc_int  = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_sys  = 5'd8,
        exc_none = 5'd31
    } exc_code_t;

    localparam word_t EXC_VECTOR = 32'hbfc0_0380;

    localparam int STATUS_IE_BIT  = 0;
    localparam int STATUS_EXL_BIT = 1;

    // software interrupt bits, IM in status and IP in cause
    localparam int SW_INT_LSB = 8;

    function automatic logic op_is_load(input op_t op);
        logic hit;
        begin
            case (op)
                op_load_word, op_load_half, op_load_linked:
                    hit = 1'b1;
                default:
                    hit = 1'b0;
            endcase
            return hit;
        end
    endfunction

    function automatic logic op_is_mem(input op_t op);
        logic hit;
        begin
            hit = op_is_load(op) | (op == op_store_word);
            return hit;
        end
    endfunction

endpackage

/* src/commit_unit.sv */
`timescale 1ns/1ps

module commit_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  commit_pkg::op_t       in_op,
    input  commit_pkg::word_t     in_pc,
    input  commit_pkg::word_t     in_addr,
    input  commit_pkg::word_t     in_result,
    input  commit_pkg::reg_addr_t in_dest,
    input  logic [5:0]            ext_int,
    input  commit_pkg::word_t     cp0_status,
    input  commit_pkg::word_t     cp0_cause,
    output logic                  finish,
    output logic                  dmem_req,
    output logic                  dmem_write,
    output commit_pkg::word_t     dmem_addr,
    output commit_pkg::word_t     dmem_wdata,
    input  logic                  dmem_addr_ok,
    input  logic                  dmem_data_ok,
    input  commit_pkg::word_t     dmem_rdata,
    output logic                  rf_wen,
    output commit_pkg::reg_addr_t rf_waddr,
    output commit_pkg::word_t     rf_wdata,
    output logic                  redirect_valid,
    output commit_pkg::word_t     redirect_pc,
    output commit_pkg::exc_code_t exc_code,
    output commit_pkg::word_t     epc,
    output logic                  llbit
);
    import commit_pkg::*;

    logic       addr_done;
    logic       data_done;
    exc_code_t  ex_code;
    logic       ex_ll;
    logic       buf_valid;
    op_t        buf_op;
    word_t      buf_pc;
    word_t      buf_result;
    reg_addr_t  buf_dest;
    logic [1:0] buf_addr_low;
    exc_code_t  buf_code;

    // whole unit advances only when both stages are done
    assign finish = addr_done & data_done;

    exception_stage i_exception_stage (
        .clk, .rst_n, .in_valid, .in_op, .in_pc, .in_addr, .in_result, .in_dest,
        .ext_int, .cp0_status, .cp0_cause,
        .flush      (redirect_valid),
        .finish, .dmem_addr_ok,
        .dmem_req, .dmem_write, .dmem_addr, .dmem_wdata,
        .addr_done, .ex_code, .ex_ll
    );

    commit_buffer i_commit_buffer (
        .clk, .rst_n, .finish, .in_valid, .in_op, .in_pc, .in_result, .in_dest,
        .in_addr    (in_addr[1:0]),
        .ex_code, .ex_ll,
        .buf_valid, .buf_op, .buf_pc, .buf_result, .buf_dest, .buf_addr_low,
        .buf_code, .llbit
    );

    data_stage i_data_stage (
        .clk, .rst_n, .finish,
        .buf_valid, .buf_op, .buf_pc, .buf_result, .buf_dest, .buf_addr_low, .buf_code,
        .dmem_data_ok, .dmem_rdata,
        .data_done, .rf_wen, .rf_waddr, .rf_wdata,
        .redirect_valid, .redirect_pc, .exc_code, .epc
    );

endmodule

/* src/data_stage.sv */
`timescale 1ns/1ps

module data_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  finish,
    input  logic                  buf_valid,
    input  commit_pkg::op_t       buf_op,
    input  commit_pkg::word_t     buf_pc,
    input  commit_pkg::word_t     buf_result,
    input  commit_pkg::reg_addr_t buf_dest,
    input  logic [1:0]            buf_addr_low,
    input  commit_pkg::exc_code_t buf_code,
    input  logic                  dmem_data_ok,
    input  commit_pkg::word_t     dmem_rdata,
    output logic                  data_done,
    output logic                  rf_wen,
    output commit_pkg::reg_addr_t rf_waddr,
    output commit_pkg::word_t     rf_wdata,
    output logic                  redirect_valid,
    output commit_pkg::word_t     redirect_pc,
    output commit_pkg::exc_code_t exc_code,
    output commit_pkg::word_t     epc
);
    import commit_pkg::*;

    logic        clean;
    logic        is_load;
    logic        written;
    logic        load_wait;
    word_t       shifted;
    logic [15:0] half;

    assign clean   = buf_valid & (buf_code == exc_none);
    assign is_load = clean & op_is_load(buf_op);

    // stalls until the outstanding load data comes back
    assign load_wait = is_load & ~written & ~dmem_data_ok;
    assign data_done = ~load_wait;

    // little endian byte lanes
    assign shifted = dmem_rdata >> {buf_addr_low, 3'b000};
    assign half    = shifted[15:0];

    always_comb
    begin
        rf_wen   = 1'b0;
        rf_wdata = buf_result;
        if (clean && !written)
        begin
            case (buf_op)
                op_alu:
                    rf_wen = 1'b1;
                op_load_word, op_load_linked:
                begin
                    rf_wen   = dmem_data_ok;
                    rf_wdata = dmem_rdata;
                end
                op_load_half:
                begin
                    rf_wen   = dmem_data_ok;
                    rf_wdata = {{16{half[15]}}, half};
                end
                default:
                    rf_wen = 1'b0;
            endcase
        end
    end

    assign rf_waddr = buf_dest;

    // write already done, still held because the next op waits for its address
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            written <= 1'b0;
        else if (finish)
            written <= 1'b0;
        else if (rf_wen)
            written <= 1'b1;
    end

    assign redirect_valid = buf_valid & (buf_code != exc_none);
    assign redirect_pc    = EXC_VECTOR;
    assign exc_code       = buf_code;
    assign epc            = buf_pc;

    // load data only returns for the buffered load still waiting
    a_data_expected: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_data_ok |-> is_load && !written);

endmodule

/* src/exception_stage.sv */
`timescale 1ns/1ps

module exception_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  commit_pkg::op_t       in_op,
    input  commit_pkg::word_t     in_pc,
    input  commit_pkg::word_t     in_addr,
    input  commit_pkg::word_t     in_result,
    input  commit_pkg::reg_addr_t in_dest,
    input  logic [5:0]            ext_int,
    input  commit_pkg::word_t     cp0_status,
    input  commit_pkg::word_t     cp0_cause,
    input  logic                  flush,
    input  logic                  finish,
    input  logic                  dmem_addr_ok,
    output logic                  dmem_req,
    output logic                  dmem_write,
    output commit_pkg::word_t     dmem_addr,
    output commit_pkg::word_t     dmem_wdata,
    output logic                  addr_done,
    output commit_pkg::exc_code_t ex_code,
    output logic                  ex_ll
);
    import commit_pkg::*;

    typedef enum logic [1:0] {
        mem_idle,
        mem_wait,
        mem_acked
    } mem_state_t;

    mem_state_t state;
    mem_state_t state_next;
    logic       live;
    logic       clean;
    logic       need_addr;
    logic       irq_pending;
    logic       irq_take;
    logic       misaligned;

    // instruction behind a redirect is dropped, never reaches memory
    assign live = in_valid & ~flush;

    assign irq_pending = (|ext_int)
                       | (|(cp0_cause[SW_INT_LSB +: 2] & cp0_status[SW_INT_LSB +: 2]));

    // once the bus has seen the address the access is committed
    assign irq_take = irq_pending & cp0_status[STATUS_IE_BIT]
                    & ~cp0_status[STATUS_EXL_BIT] & (state == mem_idle);

    always_comb
    begin
        case (in_op)
            op_load_word, op_load_linked, op_store_word:
                misaligned = |in_addr[1:0];
            op_load_half:
                misaligned = in_addr[0];
            default:
                misaligned = 1'b0;
        endcase
    end

    // interrupt, then syscall, then address errors
    always_comb
    begin
        ex_code = exc_none;
        if (irq_take)
            ex_code = exc_int;
        else if (in_op == op_syscall)
            ex_code = exc_sys;
        else if (misaligned && in_op == op_store_word)
            ex_code = exc_ades;
        else if (misaligned)
            ex_code = exc_adel;
    end

    assign clean     = live & (ex_code == exc_none);
    assign need_addr = clean & op_is_mem(in_op);
    assign ex_ll     = clean & (in_op == op_load_linked);

    assign dmem_req   = need_addr & (state != mem_acked);
    assign dmem_write = (in_op == op_store_word);
    assign dmem_addr  = {in_addr[31:2], 2'b00};
    assign dmem_wdata = in_result;

    assign addr_done = ~need_addr | (state == mem_acked) | dmem_addr_ok;

    always_comb
    begin
        state_next = state;
        case (state)
            mem_idle:
            begin
                if (dmem_req && !finish && dmem_addr_ok)
                    state_next = mem_acked;
                else if (dmem_req && !finish)
                    state_next = mem_wait;
            end
            mem_wait:
            begin
                if (finish)
                    state_next = mem_idle;
                else if (dmem_addr_ok)
                    state_next = mem_acked;
            end
            default:
            begin
                if (finish)
                    state_next = mem_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= mem_idle;
        else
            state <= state_next;
    end

    // request and its fields hold until the address is taken
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req && !dmem_addr_ok |=> dmem_req && $stable(dmem_addr) && $stable(dmem_write)
            && $stable(dmem_wdata));

    // source must hold the instruction while the unit is stalled
    a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !finish |=> in_valid && $stable(in_op) && $stable(in_pc)
            && $stable(in_addr) && $stable(in_result) && $stable(in_dest));

endmodule

/* verif/commit_tb.sv */
`timescale 1ns/1ps

module commit_tb;
    import commit_pkg::*;

    localparam int NUM_INSTR   = 500;
    localparam int CYCLE_LIMIT = 40 * NUM_INSTR;
    localparam int MEM_WORDS   = 64;

    typedef enum logic [2:0] {
        pend_none,
        pend_alu,
        pend_load,
        pend_store,
        pend_exc
    } pend_t;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    op_t        in_op;
    word_t      in_pc;
    word_t      in_addr;
    word_t      in_result;
    reg_addr_t  in_dest;
    logic [5:0] ext_int;
    word_t      cp0_status;
    word_t      cp0_cause;
    logic       finish;
    logic       dmem_req;
    logic       dmem_write;
    word_t      dmem_addr;
    word_t      dmem_wdata;
    logic       dmem_addr_ok;
    logic       dmem_data_ok;
    word_t      dmem_rdata;
    logic       rf_wen;
    reg_addr_t  rf_waddr;
    word_t      rf_wdata;
    logic       redirect_valid;
    word_t      redirect_pc;
    exc_code_t  exc_code;
    word_t      epc;
    logic       llbit;

    // presented instruction
    logic       cur_valid;
    op_t        cur_op;
    word_t      cur_pc;
    word_t      cur_addr;
    word_t      cur_result;
    reg_addr_t  cur_dest;
    logic [5:0] cur_ext;
    word_t      cur_status;
    exc_code_t  cur_code;

    // instruction held between the stages
    pend_t      pend_kind;
    logic       pend_done;
    reg_addr_t  pend_dest;
    word_t      pend_data;
    exc_code_t  pend_code;
    word_t      pend_pc;
    logic       ll_exp;

    word_t      bus_mem [MEM_WORDS];
    word_t      ref_mem [MEM_WORDS];
    logic       data_pending;
    logic [5:0] data_idx;
    int         data_cnt;
    int         addr_cnt;
    logic       next_addr_ok;
    logic       next_data_ok;
    word_t      next_rdata;

    logic [31:0] lfsr;
    int          cycles;
    int          accepted;
    int          seq;

    commit_unit i_commit_unit (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        begin
            n = s >> 1;
            if (s[0])
                n = n ^ 32'h8020_0003;
            return n;
        end
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        begin
            v = '0;
            for (int i = 0; i < n; i++)
            begin
                v    = {v[30:0], lfsr[0]};
                lfsr = lfsr_next(lfsr);
            end
            return v;
        end
    endfunction

    function automatic exc_code_t expected_code(input op_t op, input word_t addr,
                                                input logic [5:0] ext, input word_t status);
        logic irq;
        begin
            irq = (ext != 6'd0) && status[STATUS_IE_BIT] && !status[STATUS_EXL_BIT];
            if (irq)
                return exc_int;
            if (op == op_syscall)
                return exc_sys;
            if (op == op_store_word && addr[1:0] != 2'b00)
                return exc_ades;
            if ((op == op_load_word || op == op_load_linked) && addr[1:0] != 2'b00)
                return exc_adel;
            if (op == op_load_half && addr[0])
                return exc_adel;
            return exc_none;
        end
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act)
            stop_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (exp !== act)
            stop_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_exc(input string name, input exc_code_t exp, input exc_code_t act);
        if (exp !== act)
            stop_run($sformatf("[FAIL] %s expected %s actual %s", name, exp.name(), act.name()));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            stop_run($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
    endtask

    task automatic new_instr();
        logic [31:0] r;
        logic [1:0]  low;
        begin
            r = take_bits(3);
            cur_valid = (r[2:0] != 3'd0);
            r = take_bits(3);
            cur_op = (r[2:0] > 3'd5) ? op_alu : op_t'(r[2:0]);
            r = take_bits(1);
            if (r[0])
            begin
                r   = take_bits(2);
                low = r[1:0];
            end
            else if (cur_op == op_load_half)
            begin
                r   = take_bits(1);
                low = {r[0], 1'b0};
            end
            else
                low = 2'b00;
            r = take_bits(6);
            cur_addr   = {24'd0, r[5:0], low};
            cur_result = take_bits(32);
            r = take_bits(5);
            cur_dest = r[4:0];
            r = take_bits(2);
            cur_ext = 6'd0;
            if (r[1:0] == 2'd0)
            begin
                r       = take_bits(6);
                cur_ext = r[5:0];
            end
            r = take_bits(5);
            // ie mostly set, exl mostly clear
            cur_status = {30'd0, r[4:2] == 3'd0, r[1:0] != 2'd0};
            cur_pc     = 32'h0040_0000 + 32'(seq) * 32'd4;
            seq++;
            cur_code = expected_code(cur_op, cur_addr, cur_ext, cur_status);
        end
    endtask

    // memory with random address and data latency, one access at a time
    task automatic memory_step();
        if (dmem_data_ok)
        begin
            next_data_ok = 1'b0;
            data_pending = 1'b0;
        end
        if (dmem_addr_ok)
        begin
            if (dmem_write)
                bus_mem[dmem_addr[7:2]] = dmem_wdata;
            else
            begin
                data_pending = 1'b1;
                data_idx     = dmem_addr[7:2];
                data_cnt     = int'(take_bits(3));
            end
            addr_cnt     = int'(take_bits(2));
            next_addr_ok = 1'b0;
        end
        else if (dmem_req && !data_pending)
        begin
            if (addr_cnt == 0)
                next_addr_ok = 1'b1;
            else
                addr_cnt--;
        end
        if (data_pending && !dmem_data_ok && !next_data_ok)
        begin
            if (data_cnt == 0)
            begin
                next_data_ok = 1'b1;
                next_rdata   = bus_mem[data_idx];
            end
            else
                data_cnt--;
        end
    endtask

    task automatic take_instr();
        logic [5:0]  idx;
        logic [15:0] h;
        begin
            idx       = cur_addr[7:2];
            pend_done = 1'b0;
            pend_dest = cur_dest;
            pend_pc   = cur_pc;
            pend_code = cur_code;
            pend_data = cur_result;
            pend_kind = pend_alu;
            if (cur_code != exc_none)
                pend_kind = pend_exc;
            else if (cur_op == op_store_word)
            begin
                pend_kind    = pend_store;
                ref_mem[idx] = cur_result;
            end
            else if (cur_op == op_load_word || cur_op == op_load_linked)
            begin
                pend_kind = pend_load;
                pend_data = ref_mem[idx];
                if (cur_op == op_load_linked)
                    ll_exp = 1'b1;
            end
            else if (cur_op == op_load_half)
            begin
                pend_kind = pend_load;
                h         = cur_addr[1] ? ref_mem[idx][31:16] : ref_mem[idx][15:0];
                pend_data = {{16{h[15]}}, h};
            end
        end
    endtask

    initial
    begin
        logic exp_wen;
        logic squash;
        logic accept;
        logic need_mem;
        logic load_open;
        logic exp_finish;
        int   drain;

        rst_n        <= 1'b0;
        in_valid     <= 1'b0;
        in_op        <= op_alu;
        in_pc        <= '0;
        in_addr      <= '0;
        in_result    <= '0;
        in_dest      <= '0;
        ext_int      <= '0;
        cp0_status   <= '0;
        cp0_cause    <= '0;
        dmem_addr_ok <= 1'b0;
        dmem_data_ok <= 1'b0;
        dmem_rdata   <= '0;
        lfsr = 32'd27;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            bus_mem[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
            ref_mem[i] = bus_mem[i];
        end
        cur_valid    = 1'b0;
        pend_kind    = pend_none;
        pend_done    = 1'b0;
        ll_exp       = 1'b0;
        data_pending = 1'b0;
        addr_cnt     = 0;
        next_addr_ok = 1'b0;
        next_data_ok = 1'b0;
        next_rdata   = '0;
        cycles       = 0;
        accepted     = 0;
        seq          = 0;
        drain        = 0;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        while (accepted < NUM_INSTR || drain < 16)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT)
                stop_run($sformatf("timeout after %0d cycles with %0d instructions committed",
                                   cycles, accepted));
            if (cycles == 1)
                check_bit("finish after reset", 1'b1, finish);

            check_bit("redirect_valid", pend_kind == pend_exc, redirect_valid);
            if (pend_kind == pend_exc)
            begin
                check_exc("exc_code", pend_code, exc_code);
                check_word("redirect_pc", EXC_VECTOR, redirect_pc);
                check_word("epc", pend_pc, epc);
            end
            load_open = (pend_kind == pend_load) && !pend_done && !dmem_data_ok;
            exp_wen = !pend_done
                    && (pend_kind == pend_alu || (pend_kind == pend_load && dmem_data_ok));
            check_bit("rf_wen", exp_wen, rf_wen);
            if (exp_wen)
            begin
                check_reg("rf_waddr", pend_dest, rf_waddr);
                check_word("rf_wdata", pend_data, rf_wdata);
                pend_done = 1'b1;
            end
            check_bit("llbit", ll_exp, llbit);

            // instruction behind a redirect is dropped
            squash   = (pend_kind == pend_exc);
            need_mem = cur_valid && !squash && cur_code == exc_none
                     && (cur_op inside {op_load_word, op_load_half, op_load_linked,
                                        op_store_word});
            check_bit("dmem_req", need_mem, dmem_req);
            if (need_mem)
            begin
                check_bit("dmem_write", cur_op == op_store_word, dmem_write);
                check_word("dmem_addr", {cur_addr[31:2], 2'b00}, dmem_addr);
                if (cur_op == op_store_word)
                    check_word("dmem_wdata", cur_result, dmem_wdata);
            end

            // stalled by a missing address grant or by outstanding load data
            exp_finish = (!need_mem || dmem_addr_ok) && !load_open;
            check_bit("finish", exp_finish, finish);

            accept = cur_valid && finish;
            if (squash)
            begin
                pend_kind = pend_none;
                ll_exp    = 1'b0;
            end
            else if (accept)
                take_instr();
            else if (finish)
                pend_kind = pend_none;
            if (accept)
                accepted++;

            memory_step();

            if (accept || !cur_valid)
            begin
                if (accepted < NUM_INSTR)
                    new_instr();
                else
                    cur_valid = 1'b0;
            end
            if (accepted >= NUM_INSTR)
                drain++;

            @(posedge clk);
            in_valid     <= cur_valid;
            in_op        <= cur_op;
            in_pc        <= cur_pc;
            in_addr      <= cur_addr;
            in_result    <= cur_result;
            in_dest      <= cur_dest;
            ext_int      <= cur_ext;
            cp0_status   <= cur_status;
            dmem_addr_ok <= next_addr_ok;
            dmem_data_ok <= next_data_ok;
            dmem_rdata   <= next_rdata;
        end

        $display("TEST PASS");
        $finish;
    end

endmodule
